// File: verilog/lz77_pkg.sv
package lz77_pkg;

  // ------------------------------
  // widths with a meaning
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  len_t;
  typedef logic [7:0]  dst_t;
  typedef logic [15:0] cnt_t;

  // shorter best matches go out as literals
  localparam int LEN_MIN = 3;

  // ------------------------------
  // token as seen by the downstream stage
  typedef struct packed {
    logic  lit;
    byte_t lit_byte;
    len_t  len;
    dst_t  dst;
    logic  last;
  } token_t;

  // ------------------------------
  // apb slave port
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {IDLE, FETCH, SEARCH, EMIT} win_state_e;

  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_LEN    = 4'h4;
  localparam logic [3:0] ADDR_STATUS = 4'h8;
  localparam logic [3:0] ADDR_TOKCNT = 4'hC;

endpackage

// File: verilog/lz77_apb_regs.sv
`timescale 1ns/1ns

module lz77_apb_regs (
  input  logic               clk,
  input  logic               rstn,
  input  lz77_pkg::apb_req_t apb_i,
  output lz77_pkg::apb_rsp_t apb_o,
  input  logic               busy_i,
  input  logic               tok_acc_i,
  input  logic               run_done_i,
  output logic               start_o,
  output lz77_pkg::cnt_t     len_cfg_o
);

  import lz77_pkg::*;

  logic        acc_w;
  logic        wr_w;
  logic        addr_ok_w;
  logic        busy_w;
  logic [31:0] rdata_w;

  cnt_t len_q;
  cnt_t tok_cnt_q;
  logic done_q;
  logic run_q;

  // ------------------------------
  // access decode
  assign acc_w  = apb_i.psel && apb_i.penable;
  assign wr_w   = acc_w && apb_i.pwrite && addr_ok_w;

  // run stays busy until the last token has left the slot
  assign busy_w = busy_i || run_q;

  always_comb begin
    addr_ok_w = 1'b1;
    rdata_w   = '0;
    case (apb_i.paddr)
      ADDR_CTRL:   rdata_w = '0;
      ADDR_LEN:    rdata_w = 32'(len_q);
      ADDR_STATUS: rdata_w = {30'd0, done_q, busy_w};
      ADDR_TOKCNT: rdata_w = 32'(tok_cnt_q);
      default:     addr_ok_w = 1'b0;
    endcase
  end

  // no wait states
  assign apb_o.prdata  = rdata_w;
  assign apb_o.pready  = 1'b1;
  assign apb_o.pslverr = acc_w && !addr_ok_w;

  // start only from idle and with a non-empty stream
  assign start_o = wr_w && (apb_i.paddr == ADDR_CTRL) && apb_i.pwdata[0] &&
                   !busy_w && (len_q != '0);

  assign len_cfg_o = len_q;

  // ------------------------------
  // registers
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      len_q     <= '0;
      tok_cnt_q <= '0;
      done_q    <= 1'b0;
      run_q     <= 1'b0;
    end else begin
      if (wr_w && (apb_i.paddr == ADDR_LEN)) begin
        len_q <= apb_i.pwdata[15:0];
      end
      if (start_o) begin
        tok_cnt_q <= '0;
        done_q    <= 1'b0;
        run_q     <= 1'b1;
      end else begin
        if (tok_acc_i) begin
          tok_cnt_q <= tok_cnt_q + cnt_t'(1);
        end
        // done is sticky until the next start
        if (run_done_i) begin
          done_q <= 1'b1;
          run_q  <= 1'b0;
        end
      end
    end
  end

endmodule

// File: verilog/lz77_window.sv
`timescale 1ns/1ns

module lz77_window #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            start_i,
  input  lz77_pkg::cnt_t                  len_cfg_i,
  output logic                            rd_val_o,
  input  lz77_pkg::byte_t                 rd_dat_i,
  output logic                            srch_go_o,
  output lz77_pkg::byte_t [WIN_SIZE-1:0]  win_o,
  output lz77_pkg::byte_t [LEN_MAX-1:0]   look_o,
  output lz77_pkg::dst_t                  win_fill_o,
  output lz77_pkg::len_t                  look_len_o,
  input  logic                            srch_done_i,
  input  lz77_pkg::len_t                  best_len_i,
  input  lz77_pkg::dst_t                  best_dst_i,
  input  logic                            slot_free_i,
  output logic                            emit_o,
  output logic                            emit_last_o,
  output logic                            busy_o
);

  import lz77_pkg::*;

  win_state_e state_q;
  win_state_e state_d;

  cnt_t       len_q;
  cnt_t       fet_cnt_q;
  cnt_t       cod_cnt_q;
  len_t       look_len_q;
  len_t       shift_len_w;
  dst_t       win_fill_q;
  dst_t       fill_sat_w;
  logic [8:0] fill_sum_w;
  logic       done_seen_q;
  logic       last_w;

  byte_t [WIN_SIZE-1:0] win_q;
  byte_t [WIN_SIZE-1:0] win_shift_w;
  byte_t [LEN_MAX-1:0]  look_q;
  byte_t [LEN_MAX-1:0]  look_shift_w;

  // ------------------------------
  // sequencer
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = FETCH;
        end
      end
      FETCH: begin
        if (srch_go_o) begin
          state_d = SEARCH;
        end
      end
      SEARCH: begin
        // hold here while the previous token still occupies the slot
        if ((srch_done_i || done_seen_q) && slot_free_i) begin
          state_d = EMIT;
        end
      end
      EMIT: begin
        state_d = last_w ? IDLE : FETCH;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // fill the lookahead until full or stream exhausted
  assign rd_val_o  = (state_q == FETCH) && (look_len_q < len_t'(LEN_MAX)) &&
                     (fet_cnt_q < len_q);
  assign srch_go_o = (state_q == FETCH) && !rd_val_o;

  // literal is marked by distance 0
  assign shift_len_w = (best_dst_i == '0) ? len_t'(1) : best_len_i;
  assign last_w      = (cod_cnt_q + cnt_t'(shift_len_w)) == len_q;
  assign emit_o      = (state_q == EMIT);
  assign emit_last_o = emit_o && last_w;
  assign busy_o      = (state_q != IDLE);

  assign fill_sum_w = 9'(win_fill_q) + 9'(shift_len_w);
  assign fill_sat_w = (fill_sum_w > 9'(WIN_SIZE)) ? dst_t'(WIN_SIZE) : fill_sum_w[7:0];

  // ------------------------------
  // window and lookahead shift by token length
  // win[0] is the most recent coded byte, look[0] the next one
  always_comb begin
    for (int j = 0; j < WIN_SIZE; j++) begin
      if (j < int'(shift_len_w)) begin
        win_shift_w[j] = look_q[int'(shift_len_w) - 1 - j];
      end else begin
        win_shift_w[j] = win_q[j - int'(shift_len_w)];
      end
    end
    for (int i = 0; i < LEN_MAX; i++) begin
      if (i + int'(shift_len_w) < LEN_MAX) begin
        look_shift_w[i] = look_q[i + int'(shift_len_w)];
      end else begin
        look_shift_w[i] = '0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q     <= IDLE;
      len_q       <= '0;
      fet_cnt_q   <= '0;
      cod_cnt_q   <= '0;
      look_len_q  <= '0;
      win_fill_q  <= '0;
      done_seen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // new run starts with an empty window
      if ((state_q == IDLE) && start_i) begin
        len_q      <= len_cfg_i;
        fet_cnt_q  <= '0;
        cod_cnt_q  <= '0;
        look_len_q <= '0;
        win_fill_q <= '0;
      end
      if (rd_val_o) begin
        fet_cnt_q  <= fet_cnt_q + cnt_t'(1);
        look_len_q <= look_len_q + len_t'(1);
      end
      if (srch_done_i) begin
        done_seen_q <= 1'b1;
      end
      if (emit_o) begin
        done_seen_q <= 1'b0;
        cod_cnt_q   <= cod_cnt_q + cnt_t'(shift_len_w);
        look_len_q  <= look_len_q - shift_len_w;
        win_fill_q  <= fill_sat_w;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_val_o) begin
      look_q[look_len_q] <= rd_dat_i;
    end
    if (emit_o) begin
      look_q <= look_shift_w;
      win_q  <= win_shift_w;
    end
  end

  assign win_o      = win_q;
  assign look_o     = look_q;
  assign win_fill_o = win_fill_q;
  assign look_len_o = look_len_q;

endmodule

// File: verilog/lz77_match_search.sv
`timescale 1ns/1ns

module lz77_match_search #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic                            srch_go_i,
  input  lz77_pkg::byte_t [WIN_SIZE-1:0]  win_i,
  input  lz77_pkg::byte_t [LEN_MAX-1:0]   look_i,
  input  lz77_pkg::dst_t                  win_fill_i,
  input  lz77_pkg::len_t                  look_len_i,
  output logic                            srch_done_o,
  output lz77_pkg::len_t                  best_len_o,
  output lz77_pkg::dst_t                  best_dst_o
);

  import lz77_pkg::*;

  // flag i stands for distance i+1
  logic [WIN_SIZE-1:0] flg_q;
  logic [WIN_SIZE-1:0] flg_init_w;
  logic [WIN_SIZE-1:0] flg_nxt_w;
  logic [WIN_SIZE-1:0] pick_src_w;

  logic active_q;
  logic done_q;
  logic any_w;
  logic stop_w;
  len_t k_q;
  len_t fin_len_w;
  dst_t pick_dst_w;
  len_t best_len_q;
  dst_t best_dst_q;

  // ------------------------------
  // candidate flags
  always_comb begin
    for (int i = 0; i < WIN_SIZE; i++) begin
      flg_init_w[i] = (i < int'(win_fill_i));
    end
  end

  // source must stay inside the window, so distance has to exceed k
  always_comb begin
    for (int i = 0; i < WIN_SIZE; i++) begin
      flg_nxt_w[i] = 1'b0;
      if (flg_q[i] && (i >= int'(k_q))) begin
        flg_nxt_w[i] = (win_i[i - int'(k_q)] == look_i[k_q]);
      end
    end
  end

  assign any_w  = |flg_nxt_w;
  assign stop_w = active_q && (!any_w || ((k_q + len_t'(1)) == look_len_i));

  // survivors of the last matching cycle all share the best length
  assign fin_len_w  = any_w ? (k_q + len_t'(1)) : k_q;
  assign pick_src_w = any_w ? flg_nxt_w : flg_q;

  // ------------------------------
  // priority pick, smallest distance wins
  always_comb begin
    pick_dst_w = '0;
    for (int i = WIN_SIZE - 1; i >= 0; i--) begin
      if (pick_src_w[i]) begin
        pick_dst_w = dst_t'(i + 1);
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      flg_q    <= '0;
      k_q      <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= stop_w;
      if (srch_go_i) begin
        flg_q    <= flg_init_w;
        k_q      <= '0;
        active_q <= 1'b1;
      end else if (active_q) begin
        flg_q <= flg_nxt_w;
        k_q   <= k_q + len_t'(1);
        if (stop_w) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // short matches fall back to a literal of length 1
  always_ff @(posedge clk) begin
    if (stop_w) begin
      if (fin_len_w >= len_t'(LEN_MIN)) begin
        best_len_q <= fin_len_w;
        best_dst_q <= pick_dst_w;
      end else begin
        best_len_q <= len_t'(1);
        best_dst_q <= '0;
      end
    end
  end

  assign srch_done_o = done_q;
  assign best_len_o  = best_len_q;
  assign best_dst_o  = best_dst_q;

endmodule

// File: verilog/lz77_token_out.sv
`timescale 1ns/1ns

module lz77_token_out (
  input  logic             clk,
  input  logic             rstn,
  input  logic             emit_i,
  input  logic             emit_last_i,
  input  lz77_pkg::len_t   best_len_i,
  input  lz77_pkg::dst_t   best_dst_i,
  input  lz77_pkg::byte_t  lit_byte_i,
  output lz77_pkg::token_t tok_o,
  output logic             tok_val_o,
  input  logic             tok_rdy_i,
  output logic             slot_free_o,
  output logic             tok_acc_o,
  output logic             run_done_o
);

  import lz77_pkg::*;

  token_t tok_q;
  token_t tok_w;
  logic   lit_w;
  logic   val_q;

  // ------------------------------
  // token forming
  // search result with distance 0 marks a literal
  assign lit_w = (best_dst_i == '0);

  always_comb begin
    tok_w.lit      = lit_w;
    tok_w.lit_byte = lit_w ? lit_byte_i : '0;
    tok_w.len      = lit_w ? len_t'(1) : best_len_i;
    tok_w.dst      = lit_w ? '0 : best_dst_i;
    tok_w.last     = emit_last_i;
  end

  // ------------------------------
  // one-entry output slot
  assign tok_acc_o   = val_q && tok_rdy_i;
  assign run_done_o  = tok_acc_o && tok_q.last;
  // free again in the cycle the held token is taken
  assign slot_free_o = !val_q || tok_rdy_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      val_q <= 1'b0;
    end else begin
      if (emit_i) begin
        val_q <= 1'b1;
      end else if (tok_acc_o) begin
        val_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (emit_i) begin
      tok_q <= tok_w;
    end
  end

  assign tok_o     = tok_q;
  assign tok_val_o = val_q;

endmodule

// File: verilog/lz77_top.sv
`timescale 1ns/1ns

module lz77_top #(
  parameter int WIN_SIZE = 16,
  parameter int LEN_MAX  = 8
) (
  input  logic               clk,
  input  logic               rstn,
  input  lz77_pkg::apb_req_t apb_i,
  output lz77_pkg::apb_rsp_t apb_o,
  output logic               rd_val_o,
  input  lz77_pkg::byte_t    rd_dat_i,
  output lz77_pkg::token_t   tok_o,
  output logic               tok_val_o,
  input  logic               tok_rdy_i
);

  import lz77_pkg::*;

  // ------------------------------
  // control between blocks
  logic start;
  cnt_t len_cfg;
  logic busy;
  logic tok_acc;
  logic run_done;
  logic slot_free;
  logic emit;
  logic emit_last;

  // search request and result
  logic                 srch_go;
  logic                 srch_done;
  byte_t [WIN_SIZE-1:0] win;
  byte_t [LEN_MAX-1:0]  look;
  dst_t                 win_fill;
  len_t                 look_len;
  len_t                 best_len;
  dst_t                 best_dst;

  lz77_apb_regs u_apb_regs (
    .clk        (clk),
    .rstn       (rstn),
    .apb_i      (apb_i),
    .apb_o      (apb_o),
    .busy_i     (busy),
    .tok_acc_i  (tok_acc),
    .run_done_i (run_done),
    .start_o    (start),
    .len_cfg_o  (len_cfg)
  );

  lz77_window #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) u_window (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start),
    .len_cfg_i   (len_cfg),
    .rd_val_o    (rd_val_o),
    .rd_dat_i    (rd_dat_i),
    .srch_go_o   (srch_go),
    .win_o       (win),
    .look_o      (look),
    .win_fill_o  (win_fill),
    .look_len_o  (look_len),
    .srch_done_i (srch_done),
    .best_len_i  (best_len),
    .best_dst_i  (best_dst),
    .slot_free_i (slot_free),
    .emit_o      (emit),
    .emit_last_o (emit_last),
    .busy_o      (busy)
  );

  lz77_match_search #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) u_match_search (
    .clk         (clk),
    .rstn        (rstn),
    .srch_go_i   (srch_go),
    .win_i       (win),
    .look_i      (look),
    .win_fill_i  (win_fill),
    .look_len_i  (look_len),
    .srch_done_o (srch_done),
    .best_len_o  (best_len),
    .best_dst_o  (best_dst)
  );

  // the literal byte is the head of the lookahead
  lz77_token_out u_token_out (
    .clk         (clk),
    .rstn        (rstn),
    .emit_i      (emit),
    .emit_last_i (emit_last),
    .best_len_i  (best_len),
    .best_dst_i  (best_dst),
    .lit_byte_i  (look[0]),
    .tok_o       (tok_o),
    .tok_val_o   (tok_val_o),
    .tok_rdy_i   (tok_rdy_i),
    .slot_free_o (slot_free),
    .tok_acc_o   (tok_acc),
    .run_done_o  (run_done)
  );

endmodule

// File: test/lz77_tb_asserts.sv
`timescale 1ns/1ns

module lz77_tb_asserts (
  input logic             clk,
  input logic             rstn,
  input lz77_pkg::token_t tok_i,
  input logic             tok_val_i,
  input logic             tok_rdy_i
);

  import lz77_pkg::*;

  // ------------------------------
  // held token stays put until taken
  a_tok_stable: assert property (@(posedge clk) disable iff (!rstn)
    (tok_val_i && !tok_rdy_i) |=> (tok_val_i && $stable(tok_i)))
    else $error("token changed or dropped while downstream stalled");

  // a match is never shorter than the minimum length
  a_match_len: assert property (@(posedge clk) disable iff (!rstn)
    (tok_val_i && !tok_i.lit) |-> (tok_i.len >= len_t'(LEN_MIN)))
    else $error("match token with length below minimum");

  // slot is empty right after reset
  a_val_after_rst: assert property (@(posedge clk)
    !rstn |=> !tok_val_i)
    else $error("token valid in the cycle after reset");

endmodule

// File: test/lz77_tb.sv
`timescale 1ns/1ns

module lz77_tb;

  import lz77_pkg::*;

  localparam int WIN_SIZE     = 16;
  localparam int LEN_MAX      = 8;
  localparam int STREAM_DEPTH = 512;
  localparam logic [31:0] SEED = 32'ha116_6491;

  // room for a full search plus a stall per byte of all runs
  localparam int TOTAL_BYTES  = 20 + 24 + 200 + 2 * 32;
  localparam int WATCHDOG_CYC = TOTAL_BYTES * (LEN_MAX + 4) * 2 + 4000;

  logic     clk;
  logic     rstn;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     rd_val;
  byte_t    rd_dat;
  token_t   tok;
  logic     tok_val;
  logic     tok_rdy;

  byte_t       stream [STREAM_DEPTH];
  int          rd_cnt;
  int          src_off;
  int          run_base;
  logic        rdy_rand;
  logic [31:0] gen_seed;
  token_t      got_q [$];
  token_t      exp_q [$];

  lz77_top #(
    .WIN_SIZE (WIN_SIZE),
    .LEN_MAX  (LEN_MAX)
  ) u_lz77_top (
    .clk       (clk),
    .rstn      (rstn),
    .apb_i     (apb_req),
    .apb_o     (apb_rsp),
    .rd_val_o  (rd_val),
    .rd_dat_i  (rd_dat),
    .tok_o     (tok),
    .tok_val_o (tok_val),
    .tok_rdy_i (tok_rdy)
  );

  bind lz77_token_out lz77_tb_asserts u_tok_asserts (
    .clk       (clk),
    .rstn      (rstn),
    .tok_i     (tok_o),
    .tok_val_i (tok_val_o),
    .tok_rdy_i (tok_rdy_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ------------------------------
  // upstream byte source with runs laid out back to back in stream
  initial begin
    rd_dat = '0;
    rd_cnt = 0;
    forever begin
      @(posedge clk);
      if (rd_val) begin
        rd_cnt <= rd_cnt + 1;
        rd_dat <= stream[(rd_cnt + 1) % STREAM_DEPTH];
      end else begin
        rd_dat <= stream[rd_cnt % STREAM_DEPTH];
      end
    end
  end

  // downstream sink that may stall at random
  initial begin : tok_sink
    logic [31:0] rdy_seed;
    rdy_seed = SEED;
    tok_rdy  = 1'b1;
    forever begin
      @(posedge clk);
      if (tok_val && tok_rdy) begin
        got_q.push_back(tok);
      end
      if (rdy_rand) begin
        rdy_seed = lcg_next(rdy_seed);
        tok_rdy <= rdy_seed[20];
      end else begin
        tok_rdy <= 1'b1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYC);
    $display("TEST FAILED");
    $fatal(1, "watchdog");
  end

  // ------------------------------
  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [3:0] addr,
                          input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    // response is settled mid access phase
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check_val("pready", 32'(apb_rsp.pready), 32'd1);
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_val("pslverr", 32'(err), 32'd0);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check_val("pslverr", 32'(err), 32'd0);
  endtask

  // ------------------------------
  // reference coder over stream[base +: n] from an empty window
  function automatic void build_model(input int base, input int n);
    int     pos;
    int     win;
    int     len;
    int     best_len;
    int     best_dst;
    token_t t;
    exp_q.delete();
    pos = 0;
    while (pos < n) begin
      win      = (pos < WIN_SIZE) ? pos : WIN_SIZE;
      best_len = 0;
      best_dst = 0;
      for (int d = 1; d <= win; d++) begin
        len = 0;
        while ((len < d) && (len < LEN_MAX) && (pos + len < n) &&
               (stream[base + pos + len] == stream[base + pos + len - d])) begin
          len++;
        end
        // strict compare keeps the smallest distance on a tie
        if (len > best_len) begin
          best_len = len;
          best_dst = d;
        end
      end
      t = '0;
      if (best_len >= LEN_MIN) begin
        t.len = len_t'(best_len);
        t.dst = dst_t'(best_dst);
      end else begin
        t.lit      = 1'b1;
        t.lit_byte = stream[base + pos];
        t.len      = len_t'(1);
        best_len   = 1;
      end
      pos   += best_len;
      t.last = (pos == n);
      exp_q.push_back(t);
    end
  endfunction

  task automatic start_run(input int n);
    build_model(src_off, n);
    run_base = got_q.size();
    src_off += n;
    apb_write(ADDR_LEN, 32'(n));
    apb_write(ADDR_CTRL, 32'd1);
  endtask

  task automatic finish_run(input int n);
    logic [31:0] rd;
    int          polls;
    int          cnt;
    int          len_sum;
    token_t      t;
    rd    = '0;
    polls = 0;
    while (!rd[1] && (polls <= n * (LEN_MAX + 4) + 50)) begin
      apb_read(ADDR_STATUS, rd);
      polls++;
    end
    if (!rd[1]) begin
      $display("run of %0d bytes never set the done bit", n);
      $display("TEST FAILED");
      $fatal(1, "run timeout");
    end
    cnt = got_q.size() - run_base;
    check_val("token count", 32'(cnt), 32'(exp_q.size()));
    len_sum = 0;
    for (int i = 0; i < cnt; i++) begin
      t = got_q[run_base + i];
      check_val($sformatf("tok_o[%0d]", i), 32'(t), 32'(exp_q[i]));
      len_sum += int'(t.len);
    end
    check_val("token length sum", 32'(len_sum), 32'(n));
    check_val("bytes read", 32'(rd_cnt), 32'(src_off));
    apb_read(ADDR_TOKCNT, rd);
    check_val("TOKCNT", rd, 32'(exp_q.size()));
    apb_read(ADDR_STATUS, rd);
    check_val("STATUS", rd, 32'h2);
  endtask

  // ------------------------------
  // directed tests
  task automatic register_access();
    logic [31:0] rd;
    logic        err;
    check_val("rd_val_o", 32'(rd_val), 32'd0);
    check_val("tok_val_o", 32'(tok_val), 32'd0);
    apb_read(ADDR_STATUS, rd);
    check_val("STATUS", rd, 32'h0);
    apb_read(ADDR_TOKCNT, rd);
    check_val("TOKCNT", rd, 32'h0);
    apb_write(ADDR_LEN, 32'h1234);
    apb_read(ADDR_LEN, rd);
    check_val("LEN", rd, 32'h1234);
    apb_xfer(1'b0, 4'h2, 32'd0, rd, err);
    check_val("pslverr", 32'(err), 32'd1);
    apb_xfer(1'b1, 4'h6, 32'h55, rd, err);
    check_val("pslverr", 32'(err), 32'd1);
    apb_read(ADDR_LEN, rd);
    check_val("LEN", rd, 32'h1234);
    // zero length start stays idle
    apb_write(ADDR_LEN, 32'd0);
    apb_write(ADDR_CTRL, 32'd1);
    apb_read(ADDR_STATUS, rd);
    check_val("STATUS", rd, 32'h0);
  endtask

  task automatic distinct_literals();
    int     lit_cnt;
    int     last_cnt;
    token_t t;
    for (int i = 0; i < 20; i++) begin
      stream[src_off + i] = byte_t'(i * 37 + 5);
    end
    start_run(20);
    finish_run(20);
    lit_cnt  = 0;
    last_cnt = 0;
    for (int i = run_base; i < got_q.size(); i++) begin
      t = got_q[i];
      lit_cnt  += int'(t.lit);
      last_cnt += int'(t.last);
    end
    check_val("literal tokens", 32'(lit_cnt), 32'd20);
    check_val("last flags", 32'(last_cnt), 32'd1);
  endtask

  task automatic repeated_pattern();
    for (int i = 0; i < 24; i++) begin
      stream[src_off + i] = byte_t'(8'h41 + (i % 4));
    end
    start_run(24);
    finish_run(24);
  endtask

  task automatic random_backpressure();
    for (int i = 0; i < 200; i++) begin
      gen_seed = lcg_next(gen_seed);
      stream[src_off + i] = byte_t'(8'h30 + gen_seed[17:16]);
    end
    rdy_rand = 1'b1;
    start_run(200);
    finish_run(200);
    rdy_rand = 1'b0;
  endtask

  task automatic busy_start_restart();
    logic [31:0] rd;
    for (int i = 0; i < 32; i++) begin
      stream[src_off + i]      = byte_t'(8'h61 + ((i * i) % 7));
      stream[src_off + 32 + i] = byte_t'(8'h61 + ((i * i) % 7));
    end
    start_run(32);
    repeat (6) @(posedge clk);
    apb_write(ADDR_CTRL, 32'd1);
    finish_run(32);
    // stale window bytes would show up here as an early match
    start_run(32);
    apb_read(ADDR_STATUS, rd);
    check_val("STATUS", rd, 32'h1);
    finish_run(32);
  endtask

  initial begin
    rstn     = 1'b0;
    apb_req  = '0;
    rdy_rand = 1'b0;
    gen_seed = SEED;
    src_off  = 0;
    run_base = 0;
    for (int i = 0; i < STREAM_DEPTH; i++) begin
      stream[i] = '0;
    end
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    register_access();
    distinct_literals();
    repeated_pattern();
    random_backpressure();
    busy_start_restart();
    $display("TEST OK");
    $finish;
  end

endmodule

// File: project.f
verilog/lz77_pkg.sv
verilog/lz77_apb_regs.sv
verilog/lz77_window.sv
verilog/lz77_match_search.sv
verilog/lz77_token_out.sv
verilog/lz77_top.sv
test/lz77_tb_asserts.sv
test/lz77_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the lz77 testbench with verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module lz77_tb -f project.f \
  -o lz77_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/lz77_sim > sim.log 2>&1
grep -qx "TEST OK" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
